/* hdl/fir_pkg.sv */
// Filter widths and tap count, APB register map and the APB write-word union.
package fir_pkg;

	// Number of filter taps and the width of one I or Q sample or coefficient part.
	localparam int taps = 10;
	localparam int sample_w = 8;

	// Each partial sum holds a 16-bit product plus 4 bits of growth over 10 taps.
	localparam int acc_w = 20;

	// The final complex add or subtract needs one more bit.
	localparam int out_w = 21;

	// Enough bits to index any tap.
	localparam int tap_idx_w = 4;

	// APB bus widths.
	localparam int apb_addr_w = 8;
	localparam int apb_data_w = 16;

	// Register map. Coefficient k sits at addr_coef_base + 4*k.
	localparam logic [apb_addr_w-1:0] addr_ctrl = 8'h00;
	localparam logic [apb_addr_w-1:0] addr_coef_base = 8'h10;

	// One APB write word, read as a coefficient or as the control word.
	// The decoder chooses the view from the address.
	typedef union packed {
		struct packed {
			logic signed [sample_w-1:0] i;
			logic signed [sample_w-1:0] q;
		} coef;
		struct packed {
			logic [apb_data_w-3:0] reserved;
			logic clear;
			logic enable;
		} ctrl;
	} wr_word_t;

endpackage

/* hdl/coef_if.sv */
// Interface for coefficient arrays, enable level and clear pulse from decoder to MAC.
`timescale 1ns/1ps

interface coef_if;
	import fir_pkg::*;

	// Complex coefficient for every tap, split into I and Q parts.
	logic signed [sample_w-1:0] coef_i [taps];
	logic signed [sample_w-1:0] coef_q [taps];

	// Level that lets samples into the delay line.
	logic enable;

	// Single-cycle pulse that empties the delay line.
	logic clear;

	// The decoder owns every signal.
	modport decoder (
		output coef_i,
		output coef_q,
		output enable,
		output clear
	);

	// The MAC stage only reads them.
	modport mac (
		input coef_i,
		input coef_q,
		input enable,
		input clear
	);

endinterface

/* hdl/partial_if.sv */
// Interface for the four real partial sums and their valid bit from MAC to combiner.
`timescale 1ns/1ps

interface partial_if;
	import fir_pkg::*;

	// Sums named by sample part then coefficient part.
	logic signed [acc_w-1:0] sum_ii;
	logic signed [acc_w-1:0] sum_iq;
	logic signed [acc_w-1:0] sum_qi;
	logic signed [acc_w-1:0] sum_qq;
	logic valid;

	modport mac (
		output sum_ii,
		output sum_iq,
		output sum_qi,
		output sum_qq,
		output valid
	);

	modport combiner (
		input sum_ii,
		input sum_iq,
		input sum_qi,
		input sum_qq,
		input valid
	);

endinterface

/* hdl/apb_coef_decode.sv */
// APB slave with coefficient and control registers, address decode and error response.
`timescale 1ns/1ps

module apb_coef_decode (
	input logic clock,
	input logic arst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [fir_pkg::apb_addr_w-1:0] paddr,
	input fir_pkg::wr_word_t pwdata,
	output logic [fir_pkg::apb_data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	coef_if.decoder coef
);
	import fir_pkg::*;

	logic access;
	logic ctrl_hit;
	logic coef_hit;
	logic [apb_addr_w-1:0] coef_off;
	logic [tap_idx_w-1:0] coef_idx;

	// Every transfer finishes in its first access cycle.
	assign pready = 1'b1;
	assign access = psel && penable;

	// Offset from coefficient 0. A valid slot is word aligned and below taps.
	assign coef_off = paddr - addr_coef_base;
	assign coef_idx = coef_off[tap_idx_w+1:2];
	assign ctrl_hit = (paddr == addr_ctrl);
	assign coef_hit = (paddr >= addr_coef_base) && (coef_off[1:0] == 2'b00) &&
		(coef_off[apb_addr_w-1:2] < taps);

	// Anything that is neither register is refused during the access cycle.
	assign pslverr = access && !(ctrl_hit || coef_hit);

	// Clear is decoded straight from the write, so it acts on the edge that ends
	// the access cycle and is never held in a register.
	assign coef.clear = access && pwrite && ctrl_hit && pwdata.ctrl.clear;

	// Register writes land at the end of the access cycle.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			coef.enable <= 1'b0;
			for (int k = 0; k < taps; k++) begin
				coef.coef_i[k] <= '0;
				coef.coef_q[k] <= '0;
			end
		end else if (access && pwrite) begin
			if (ctrl_hit) begin
				coef.enable <= pwdata.ctrl.enable;
			end
			if (coef_hit) begin
				coef.coef_i[coef_idx] <= pwdata.coef.i;
				coef.coef_q[coef_idx] <= pwdata.coef.q;
			end
		end
	end

	// Read data follows the address; control returns only the enable bit.
	// Unmapped addresses read as zero.
	always_comb begin
		prdata = '0;
		if (ctrl_hit) begin
			prdata[0] = coef.enable;
		end else if (coef_hit) begin
			prdata = {coef.coef_i[coef_idx], coef.coef_q[coef_idx]};
		end
	end

	// The error flag only belongs to an access cycle.
	a_slverr_in_access: assert property (
		@(posedge clock) disable iff (!arst_n) pslverr |-> (psel && penable)
	);

	// A master never raises penable outside a selected transfer.
	a_penable_needs_psel: assert property (
		@(posedge clock) disable iff (!arst_n) penable |-> psel
	);

endmodule

/* hdl/tap_mac.sv */
// Sample delay line and the four complex multiply-accumulate trees.
`timescale 1ns/1ps

module tap_mac (
	input logic clock,
	input logic arst_n,
	input logic sample_valid,
	input logic signed [fir_pkg::sample_w-1:0] sample_i,
	input logic signed [fir_pkg::sample_w-1:0] sample_q,
	coef_if.mac coef,
	partial_if.mac part
);
	import fir_pkg::*;

	// Position 0 holds the newest sample.
	logic signed [sample_w-1:0] line_i [taps];
	logic signed [sample_w-1:0] line_q [taps];
	logic signed [sample_w-1:0] line_i_next [taps];
	logic signed [sample_w-1:0] line_q_next [taps];

	logic accept;
	logic acc_valid;
	logic signed [acc_w-1:0] acc_ii;
	logic signed [acc_w-1:0] acc_iq;
	logic signed [acc_w-1:0] acc_qi;
	logic signed [acc_w-1:0] acc_qq;
	logic signed [acc_w-1:0] stage_ii;
	logic signed [acc_w-1:0] stage_iq;
	logic signed [acc_w-1:0] stage_qi;
	logic signed [acc_w-1:0] stage_qq;

	// Every offered sample is taken while the filter is enabled.
	assign accept = sample_valid && coef.enable;

	// Next delay line contents. Clear empties the history first, so a sample
	// arriving on the same edge starts a fresh history.
	always_comb begin
		line_i_next = line_i;
		line_q_next = line_q;
		if (coef.clear) begin
			for (int k = 0; k < taps; k++) begin
				line_i_next[k] = '0;
				line_q_next[k] = '0;
			end
		end
		if (accept) begin
			// Walk downward so each tap still sees the older value.
			for (int k = taps - 1; k > 0; k--) begin
				line_i_next[k] = line_i_next[k-1];
				line_q_next[k] = line_q_next[k-1];
			end
			line_i_next[0] = sample_i;
			line_q_next[0] = sample_q;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < taps; k++) begin
				line_i[k] <= '0;
				line_q[k] <= '0;
			end
		end else begin
			line_i <= line_i_next;
			line_q <= line_q_next;
		end
	end

	// The four trees run on the updated history and on the coefficients in
	// force before the accepting edge. A write on that same edge is not seen.
	always_comb begin
		acc_ii = '0;
		acc_iq = '0;
		acc_qi = '0;
		acc_qq = '0;
		for (int k = 0; k < taps; k++) begin
			acc_ii = acc_ii + acc_w'(line_i_next[k] * coef.coef_i[k]);
			acc_iq = acc_iq + acc_w'(line_i_next[k] * coef.coef_q[k]);
			acc_qi = acc_qi + acc_w'(line_q_next[k] * coef.coef_i[k]);
			acc_qq = acc_qq + acc_w'(line_q_next[k] * coef.coef_q[k]);
		end
	end

	// Sums are captured with the sample, then handed on one edge later.
	always_ff @(posedge clock) begin
		stage_ii <= acc_ii;
		stage_iq <= acc_iq;
		stage_qi <= acc_qi;
		stage_qq <= acc_qq;
		part.sum_ii <= stage_ii;
		part.sum_iq <= stage_iq;
		part.sum_qi <= stage_qi;
		part.sum_qq <= stage_qq;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			acc_valid <= 1'b0;
			part.valid <= 1'b0;
		end else begin
			acc_valid <= accept;
			part.valid <= acc_valid;
		end
	end

	// An accepted sample must carry defined data into the history.
	a_sample_known: assert property (
		@(posedge clock) disable iff (!arst_n)
		(sample_valid && coef.enable) |-> !$isunknown({sample_i, sample_q})
	);

endmodule

/* hdl/complex_combine.sv */
// Complex combiner forming real and imaginary outputs, with the output register.
`timescale 1ns/1ps

module complex_combine (
	input logic clock,
	input logic arst_n,
	partial_if.combiner part,
	output logic out_valid,
	output logic signed [fir_pkg::out_w-1:0] out_i,
	output logic signed [fir_pkg::out_w-1:0] out_q
);
	import fir_pkg::*;

	logic signed [out_w-1:0] re_next;
	logic signed [out_w-1:0] im_next;

	// (a + jb)(c + jd) gives ac - bd for the real part and ad + bc for the
	// imaginary part. Sums are sign extended first so nothing overflows.
	assign re_next = out_w'(part.sum_ii) - out_w'(part.sum_qq);
	assign im_next = out_w'(part.sum_iq) + out_w'(part.sum_qi);

	always_ff @(posedge clock) begin
		out_i <= re_next;
		out_q <= im_next;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= part.valid;
		end
	end

	// Each set of partial sums yields exactly one output, one cycle later.
	a_valid_follows: assert property (
		@(posedge clock) disable iff (!arst_n) out_valid == $past(part.valid)
	);

endmodule

/* hdl/complex_fir_top.sv */
// Top level of the complex FIR, joining APB decoder, tap MAC and combiner.
`timescale 1ns/1ps

module complex_fir_top (
	input logic clock,
	input logic arst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [fir_pkg::apb_addr_w-1:0] paddr,
	input logic [fir_pkg::apb_data_w-1:0] pwdata,
	output logic [fir_pkg::apb_data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic sample_valid,
	input logic signed [fir_pkg::sample_w-1:0] sample_i,
	input logic signed [fir_pkg::sample_w-1:0] sample_q,
	output logic out_valid,
	output logic signed [fir_pkg::out_w-1:0] out_i,
	output logic signed [fir_pkg::out_w-1:0] out_q
);

	// Coefficients and control, decoder to MAC.
	coef_if coef_bus ();

	// Partial sums, MAC to combiner.
	partial_if part_bus ();

	apb_coef_decode i_apb_coef_decode (
		.clock (clock),
		.arst_n (arst_n),
		.psel (psel),
		.penable (penable),
		.pwrite (pwrite),
		.paddr (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr (pslverr),
		.coef (coef_bus.decoder)
	);

	tap_mac i_tap_mac (
		.clock (clock),
		.arst_n (arst_n),
		.sample_valid (sample_valid),
		.sample_i (sample_i),
		.sample_q (sample_q),
		.coef (coef_bus.mac),
		.part (part_bus.mac)
	);

	complex_combine i_complex_combine (
		.clock (clock),
		.arst_n (arst_n),
		.part (part_bus.combiner),
		.out_valid (out_valid),
		.out_i (out_i),
		.out_q (out_q)
	);

endmodule

/* testbench/tb_clock_gen.sv */
// Testbench clock source with a 10 ns period and a reset held for three cycles.
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock,
	output logic arst_n
);

	localparam int half_period = 5;

	// Free running clock that starts low.
	initial begin
		clock = 1'b0;
		forever begin
			#half_period clock = ~clock;
		end
	end

	// Reset covers three rising edges and is released on a falling edge.
	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
	end

endmodule

/* testbench/tb_complex_fir.sv */
// Testbench for the complex FIR: APB and sample stimulus, reference model, checker, watchdog.
`timescale 1ns/1ps

module tb_complex_fir;
	import fir_pkg::*;

	// Upper bound on APB transfers and samples driven, which sizes the watchdog.
	localparam int planned_transactions = 300;
	localparam int clock_period = 10;

	// Rising edges from the accepting edge to the edge that raises out_valid.
	localparam int out_latency = 2;

	logic clock;
	logic arst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apb_addr_w-1:0] paddr;
	logic [apb_data_w-1:0] pwdata;
	logic [apb_data_w-1:0] prdata;
	logic pready;
	logic pslverr;
	logic sample_valid;
	logic signed [sample_w-1:0] sample_i;
	logic signed [sample_w-1:0] sample_q;
	logic out_valid;
	logic signed [out_w-1:0] out_i;
	logic signed [out_w-1:0] out_q;

	// Model of the filter state, updated on every rising edge.
	logic [31:0] rng_state = 32'd25054;
	logic signed [sample_w-1:0] model_ci [taps];
	logic signed [sample_w-1:0] model_cq [taps];
	logic signed [sample_w-1:0] hist_i [taps];
	logic signed [sample_w-1:0] hist_q [taps];
	logic model_enable;
	int cycle_count;

	// Expected results in the order the samples were accepted.
	int exp_re_q [$];
	int exp_im_q [$];
	int exp_cycle_q [$];

	// Register contents as written by the test, for read-back.
	logic [apb_data_w-1:0] written_coef [taps];
	logic written_enable;

	tb_clock_gen i_tb_clock_gen (
		.clock (clock),
		.arst_n (arst_n)
	);

	complex_fir_top i_complex_fir_top (
		.clock (clock),
		.arst_n (arst_n),
		.psel (psel),
		.penable (penable),
		.pwrite (pwrite),
		.paddr (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr (pslverr),
		.sample_valid (sample_valid),
		.sample_i (sample_i),
		.sample_q (sample_q),
		.out_valid (out_valid),
		.out_i (out_i),
		.out_q (out_q)
	);

	// 32-bit xorshift generator.
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Coefficient slot for an address, or -1 when the address holds no coefficient.
	function automatic int coef_slot(input logic [apb_addr_w-1:0] addr);
		int off;
		off = int'(addr) - int'(addr_coef_base);
		if (off >= 0 && off % 4 == 0 && off / 4 < taps) begin
			return off / 4;
		end
		return -1;
	endfunction

	// Complex dot product of the sample history with the coefficients.
	// Ten taps of 8 by 8 products always fit the 21-bit output, so no wrap is modelled.
	function automatic void reference_output(output int re, output int im);
		re = 0;
		im = 0;
		for (int k = 0; k < taps; k++) begin
			re += int'(hist_i[k]) * int'(model_ci[k]) - int'(hist_q[k]) * int'(model_cq[k]);
			im += int'(hist_i[k]) * int'(model_cq[k]) + int'(hist_q[k]) * int'(model_ci[k]);
		end
	endfunction

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "Simulation stopped at the first failure.");
	endtask

	task automatic check_equal(input string name, input int got, input int expected);
		assert (got == expected) else begin
			stop_on_failure($sformatf("Error: time %0t, %s expected %0d, got %0d",
				$time, name, expected, got));
		end
	endtask

	// Model update. Clear acts before the shift, and register writes land after
	// the sample of the same edge has used the old coefficients.
	always @(posedge clock or negedge arst_n) begin
		int slot;
		int re;
		int im;
		logic access;
		if (!arst_n) begin
			model_enable = 1'b0;
			cycle_count = 0;
			for (int k = 0; k < taps; k++) begin
				model_ci[k] = '0;
				model_cq[k] = '0;
				hist_i[k] = '0;
				hist_q[k] = '0;
			end
		end else begin
			cycle_count++;
			access = psel && penable;
			slot = coef_slot(paddr);
			if (access && pwrite && paddr == addr_ctrl && pwdata[1]) begin
				for (int k = 0; k < taps; k++) begin
					hist_i[k] = '0;
					hist_q[k] = '0;
				end
			end
			if (sample_valid && model_enable) begin
				for (int k = taps - 1; k > 0; k--) begin
					hist_i[k] = hist_i[k-1];
					hist_q[k] = hist_q[k-1];
				end
				hist_i[0] = sample_i;
				hist_q[0] = sample_q;
				reference_output(re, im);
				exp_re_q.push_back(re);
				exp_im_q.push_back(im);
				exp_cycle_q.push_back(cycle_count);
			end
			if (access && pwrite && paddr == addr_ctrl) begin
				model_enable = pwdata[0];
			end
			if (access && pwrite && slot >= 0) begin
				model_ci[slot] = pwdata[15:8];
				model_cq[slot] = pwdata[7:0];
			end
		end
	end

	// Outputs are compared on the falling edge, half a cycle after they change.
	// Every result is due a fixed two cycles after the edge that took its sample.
	always @(negedge clock) begin
		int latency;
		if (arst_n && out_valid) begin
			assert (exp_re_q.size() > 0) else begin
				stop_on_failure("An output appeared with no accepted sample behind it.");
			end
			latency = cycle_count - exp_cycle_q.pop_front();
			check_equal("output latency", latency, out_latency);
			check_equal("out_i", int'(out_i), exp_re_q.pop_front());
			check_equal("out_q", int'(out_q), exp_im_q.pop_front());
		end
	end

	// One APB transfer, entered and left on a falling edge.
	task automatic apb_transfer(input logic write, input logic [apb_addr_w-1:0] addr,
			input logic [apb_data_w-1:0] wdata, output logic [apb_data_w-1:0] rdata,
			output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clock);
		penable = 1'b1;
		// Read data and the error flag have settled long before the closing edge.
		#2;
		rdata = prdata;
		err = pslverr;
		check_equal("pready", int'(pready), 1);
		@(negedge clock);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [apb_addr_w-1:0] addr,
			input logic [apb_data_w-1:0] data, input logic bad);
		logic [apb_data_w-1:0] rdata;
		logic err;
		apb_transfer(1'b1, addr, data, rdata, err);
		check_equal("pslverr", int'(err), int'(bad));
	endtask

	task automatic apb_read_check(input logic [apb_addr_w-1:0] addr,
			input logic [apb_data_w-1:0] expected, input logic bad);
		logic [apb_data_w-1:0] rdata;
		logic err;
		apb_transfer(1'b0, addr, '0, rdata, err);
		check_equal("pslverr", int'(err), int'(bad));
		check_equal("prdata", int'(rdata), int'(expected));
	endtask

	task automatic write_ctrl(input logic enable, input logic clear);
		apb_write(addr_ctrl, {14'b0, clear, enable}, 1'b0);
		written_enable = enable;
	endtask

	task automatic check_registers();
		for (int k = 0; k < taps; k++) begin
			apb_read_check(addr_coef_base + 8'(4 * k), written_coef[k], 1'b0);
		end
		apb_read_check(addr_ctrl, {15'b0, written_enable}, 1'b0);
	endtask

	task automatic drive_sample(input logic valid, input logic [sample_w-1:0] si,
			input logic [sample_w-1:0] sq);
		sample_valid = valid;
		sample_i = si;
		sample_q = sq;
		@(negedge clock);
	endtask

	// Random samples, roughly one in four preceded by one to three idle cycles.
	task automatic stream_random(input int count);
		logic [31:0] r;
		for (int n = 0; n < count; n++) begin
			r = next_random();
			if (r[1:0] == 2'b00) begin
				repeat (1 + r[3:2] % 3) drive_sample(1'b0, '0, '0);
			end
			drive_sample(1'b1, r[15:8], r[23:16]);
		end
		sample_valid = 1'b0;
	endtask

	// Pending results are due within the pipeline latency, so the wait is short.
	task automatic wait_drain();
		for (int n = 0; n < out_latency + 2 && exp_re_q.size() != 0; n++) begin
			@(negedge clock);
		end
		// Idle cycles expose any output that has no sample behind it.
		repeat (6) @(negedge clock);
	endtask

	initial begin
		logic [apb_data_w-1:0] word;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		sample_valid = 1'b0;
		sample_i = '0;
		sample_q = '0;
		written_enable = 1'b0;
		@(posedge arst_n);
		@(negedge clock);

		// Reset state, then coefficient and control read-back.
		check_equal("out_valid", int'(out_valid), 0);
		check_equal("pslverr", int'(pslverr), 0);
		for (int k = 0; k < taps; k++) begin
			word = 16'(next_random());
			written_coef[k] = word;
			apb_write(addr_coef_base + 8'(4 * k), word, 1'b0);
		end
		check_registers();
		write_ctrl(1'b1, 1'b0);
		apb_read_check(addr_ctrl, 16'h0001, 1'b0);
		write_ctrl(1'b0, 1'b0);
		apb_read_check(addr_ctrl, 16'h0000, 1'b0);

		// Past the last coefficient, unmapped and off-grid addresses are all refused.
		apb_write(addr_coef_base + 8'(4 * taps), 16'hffff, 1'b1);
		apb_write(8'h04, 16'h0001, 1'b1);
		apb_write(8'h12, 16'h5a5a, 1'b1);
		apb_read_check(addr_coef_base + 8'(4 * taps), 16'h0000, 1'b1);
		apb_read_check(8'hf0, 16'h0000, 1'b1);
		check_registers();

		// Impulse on a cleared line walks through the coefficients tap by tap.
		write_ctrl(1'b1, 1'b1);
		drive_sample(1'b1, 8'sd1, 8'sd0);
		repeat (taps) drive_sample(1'b1, 8'sd0, 8'sd0);
		sample_valid = 1'b0;
		wait_drain();

		// Random stream with a coefficient rewrite while samples keep flowing.
		stream_random(100);
		word = 16'(next_random());
		written_coef[3] = word;
		fork
			stream_random(100);
			apb_write(addr_coef_base + 8'(4 * 3), word, 1'b0);
		join
		wait_drain();

		// Disabled samples are dropped and the history survives them.
		write_ctrl(1'b0, 1'b0);
		repeat (5) drive_sample(1'b1, 8'(next_random()), 8'(next_random()));
		sample_valid = 1'b0;
		wait_drain();
		write_ctrl(1'b1, 1'b0);
		stream_random(4);
		wait_drain();

		// Clear empties the history for the samples that follow.
		write_ctrl(1'b1, 1'b1);
		stream_random(taps);
		wait_drain();
		check_registers();

		if (exp_re_q.size() != 0) begin
			stop_on_failure("Some accepted samples never produced an output.");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

	// Twenty cycles per transaction is far more than any transfer or sample needs.
	initial begin
		#(planned_transactions * 20 * clock_period + 1000);
		stop_on_failure("Timeout: the test sequence did not finish in time.");
	end

endmodule

/* complex_fir_top.f */
hdl/fir_pkg.sv
hdl/coef_if.sv
hdl/partial_if.sv
hdl/apb_coef_decode.sv
hdl/tap_mac.sv
hdl/complex_combine.sv
hdl/complex_fir_top.sv
testbench/tb_clock_gen.sv
testbench/tb_complex_fir.sv

/* run_sim.sh */
#!/bin/sh
# Build the complex FIR testbench with Verilator, run it and look for the pass line.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_complex_fir \
	-f complex_fir_top.f -o sim_complex_fir
output=$(./obj_dir/sim_complex_fir) || true
echo "$output"
if echo "$output" | grep -q "^All checks passed$"; then
	exit 0
else
	exit 1
fi
